// ==== test/os_patterns.txt ====
# M addr user_info shop_info : preload one account, fields in hex
# C act new_id usr_id has_slr slr_id item num amount exp_err exp_info : one command
# E addr user_info shop_info : expected account in memory at that point
M 01 13880000 080033B6
M 10 FDE80000 28552000
M 02 00640000 F8005000
# Buy with promotion Copper to Silver
C 1 1 01 1 10 1 01 0000 0 12164110
E 01 12164110 0C002000
E 10 FF140000 24552000
# Buy with the previous user id, seller money saturates
C 1 0 00 1 10 2 03 0000 0 0F8C8310
E 01 0F8C8310 0C302078
E 10 FFFF0000 24252000
# Buy error priority
C 1 1 02 1 10 1 0C 0000 4 00000000
C 1 0 00 1 10 2 05 0000 2 00000000
C 1 0 00 1 10 3 01 0000 3 00000000
E 02 00640000 F8005000
E 10 FFFF0000 24252000
# Deposit, then a full wallet
C 4 0 00 0 00 0 00 03E8 0 0000044C
C 4 0 00 0 00 0 00 FBB3 8 00000000
E 02 044C0000 F8005000
# Check own money, seller stock, own money again
C 2 1 01 0 00 0 00 0000 0 00000F8C
C 2 0 00 1 10 0 00 0000 0 00009094
C 2 0 00 0 00 0 00 0000 0 00000F8C
E 01 0F8C8310 0C302078

// ==== os_top.f ====
src/os_pkg.sv
src/os_mem_pkg.sv
src/os_if.sv
src/cmd_decode.sv
src/acct_bridge.sv
src/trade_exec.sv
src/result_format.sv
src/os_top.sv
test/os_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module os_tb -f os_top.f -o os_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/os_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

// ==== test/os_tb.sv ====
/*
 * Testbench for the shop-account controller
 * Clock, reset, account memory model with random stalls
 * Pattern reader and compare tasks
 */
`timescale 1ns/1ps
`default_nettype none

module os_tb import os_pkg::*, os_mem_pkg::*; ();

	localparam int          CLK_HALF    = 50;
	localparam int          RESULT_WAIT = 400;
	localparam logic [31:0] SEED        = 32'h7723fb7b;

	// Host pulse kinds
	localparam int P_ID   = 0;
	localparam int P_ACT  = 1;
	localparam int P_ITEM = 2;
	localparam int P_NUM  = 3;
	localparam int P_AMNT = 4;

	logic        clk = 1'b0;
	logic        inf;
	logic [31:0] d;
	logic        id_valid;
	logic        act_valid;
	logic        item_valid;
	logic        num_valid;
	logic        amnt_valid;
	logic        out_valid;
	logic        complete;
	err_t        err_msg;
	logic [31:0] out_info;
	logic        mem_req_valid;
	logic        mem_req_ready;
	logic        mem_r_wb;
	mem_addr_t   mem_addr;
	mem_word_t   mem_wdata;
	logic        mem_resp_valid;
	mem_word_t   mem_rdata;

	mem_word_t mem_model [0:255];

	int   err_fails   = 0;
	int   info_fails  = 0;
	int   flag_fails  = 0;
	int   word_fails  = 0;
	int   other_fails = 0;
	int   proto_fails = 0;
	int   pulse_total = 0;
	logic aborted     = 1'b0;

	always #CLK_HALF clk = ~clk;

	os_top UUT (
		.clk, .inf, .d, .id_valid, .act_valid, .item_valid, .num_valid, .amnt_valid,
		.out_valid, .complete, .err_msg, .out_info,
		.mem_req_valid, .mem_req_ready, .mem_r_wb, .mem_addr, .mem_wdata,
		.mem_resp_valid, .mem_rdata
	);

	// --------------------------------------------------
	// Stored word keeps bytes reversed in each half
	function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 4; i++)
			r[8*i +: 8] = w[8*(3-i) +: 8];
		return r;
	endfunction

	// User half on top, shop half below
	function automatic mem_word_t stored_word(input logic [31:0] usr_half,
		input logic [31:0] shop_half);
		return {reverse_bytes(usr_half), reverse_bytes(shop_half)};
	endfunction

	// --------------------------------------------------
	// Compare tasks
	task automatic check_err(input err_t got, input err_t exp, input int n);
		if (got !== exp) begin
			$display("ERROR: err_msg got 0x%h expected 0x%h in command %0d", got, exp, n);
			err_fails++;
		end
	endtask

	task automatic check_info(input logic [31:0] got, input logic [31:0] exp, input int n);
		if (got !== exp) begin
			$display("ERROR: out_info got 0x%h expected 0x%h in command %0d", got, exp, n);
			info_fails++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name,
		input int n);
		if (got !== exp) begin
			$display("ERROR: %s got 0x%h expected 0x%h in command %0d", name, got, exp, n);
			flag_fails++;
		end
	endtask

	task automatic check_word(input mem_word_t got, input mem_word_t exp, input mem_addr_t a);
		if (got !== exp) begin
			$display("ERROR: mem[0x%h] got 0x%h expected 0x%h", a, got, exp);
			word_fails++;
		end
	endtask

	// --------------------------------------------------
	// Host side
	task automatic drive_pulse(input int kind, input logic [31:0] value);
		@(posedge clk);
		#1;
		d          = value;
		id_valid   = (kind == P_ID);
		act_valid  = (kind == P_ACT);
		item_valid = (kind == P_ITEM);
		num_valid  = (kind == P_NUM);
		amnt_valid = (kind == P_AMNT);
		@(posedge clk);
		#1;
		d          = '0;
		id_valid   = 1'b0;
		act_valid  = 1'b0;
		item_valid = 1'b0;
		num_valid  = 1'b0;
		amnt_valid = 1'b0;
	endtask

	task automatic wait_result(input int n, output logic seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < RESULT_WAIT) begin
			@(posedge clk);
			#1;
			seen = out_valid;
			cycles++;
		end
		if (!seen) begin
			$display("Timed out waiting for out_valid in command %0d", n);
			other_fails++;
		end
	endtask

	// One command and then its result
	task automatic run_command(input logic [3:0] act, input logic new_id, input user_id_t uid,
		input logic has_slr, input user_id_t sid, input logic [1:0] item, input item_num_t num,
		input money_t amnt, input err_t exp_err, input logic [31:0] exp_info, input int n);
		logic seen;
		if (new_id)
			drive_pulse(P_ID, {24'd0, uid});
		drive_pulse(P_ACT, {28'd0, act});
		case (action_t'(act))
			Buy: begin
				drive_pulse(P_ITEM, {30'd0, item});
				drive_pulse(P_NUM, {26'd0, num});
				drive_pulse(P_ID, {24'd0, sid});
			end
			Deposit: drive_pulse(P_AMNT, {16'd0, amnt});
			default: begin
				// Check with the seller id inside the window
				if (has_slr)
					drive_pulse(P_ID, {24'd0, sid});
			end
		endcase
		wait_result(n, seen);
		if (!seen) begin
			aborted = 1'b1;
		end else begin
			check_err(err_msg, exp_err, n);
			check_info(out_info, exp_info, n);
			check_flag(complete, exp_err == No_Err, "complete", n);
			// Pulse is exactly one cycle wide
			@(posedge clk);
			#1;
			check_flag(out_valid, 1'b0, "out_valid", n);
		end
	endtask

	// --------------------------------------------------
	// Account memory model
	initial begin : mem_proc
		logic      armed;
		logic      a_rwb;
		mem_addr_t a_addr;
		mem_word_t a_wdata;
		logic      pend;
		int        p_wait;
		mem_word_t p_data;
		void'($urandom(SEED));
		mem_req_ready  = 1'b0;
		mem_resp_valid = 1'b0;
		mem_rdata      = '0;
		armed          = 1'b0;
		pend           = 1'b0;
		p_wait         = 0;
		p_data         = '0;
		forever begin
			@(posedge clk);
			#1;
			mem_resp_valid = 1'b0;
			if (!inf) begin
				armed = 1'b0;
				pend  = 1'b0;
			end else if (armed) begin
				// Request taken on the edge just passed
				if (pend) begin
					$display("Memory request accepted while another was still outstanding");
					proto_fails++;
				end
				pend   = 1'b1;
				p_wait = int'($urandom % 5);
				if (a_rwb) begin
					p_data = mem_model[a_addr];
				end else begin
					mem_model[a_addr] = a_wdata;
					p_data            = '0;
				end
			end else if (pend) begin
				if (p_wait == 0) begin
					mem_resp_valid = 1'b1;
					mem_rdata      = p_data;
					pend           = 1'b0;
				end else begin
					p_wait--;
				end
			end
			// Random stall on the request channel
			mem_req_ready = ($urandom % 4) != 0;
			armed         = inf && mem_req_valid && mem_req_ready;
			a_rwb         = mem_r_wb;
			a_addr        = mem_addr;
			a_wdata       = mem_wdata;
		end
	end

	// Result pulses over the whole run
	initial begin : pulse_count
		forever begin
			@(posedge clk);
			#1;
			if (inf && out_valid)
				pulse_total++;
		end
	end

	// --------------------------------------------------
	// Main sequence
	initial begin
		int          fd;
		int          n;
		int          cmd_no;
		int          total;
		string       line;
		string       rest;
		byte         tag;
		logic [7:0]  w_addr;
		logic [31:0] w_usr;
		logic [31:0] w_shop;
		logic [3:0]  c_act;
		logic        c_nid;
		user_id_t    c_uid;
		logic        c_hs;
		user_id_t    c_sid;
		logic [1:0]  c_item;
		item_num_t   c_num;
		money_t      c_amnt;
		logic [3:0]  c_err;
		logic [31:0] c_info;
		inf        = 1'b0;
		d          = '0;
		id_valid   = 1'b0;
		act_valid  = 1'b0;
		item_valid = 1'b0;
		num_valid  = 1'b0;
		amnt_valid = 1'b0;
		cmd_no     = 0;
		// Fill pattern from the full address
		for (int i = 0; i < 256; i++)
			mem_model[i] = {8{8'(i)}};
		repeat (4) @(posedge clk);
		#1;
		inf = 1'b1;
		check_flag(out_valid, 1'b0, "out_valid", 0);
		check_flag(complete, 1'b0, "complete", 0);
		check_flag(mem_req_valid, 1'b0, "mem_req_valid", 0);
		check_err(err_msg, No_Err, 0);

		fd = $fopen("test/os_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file test/os_patterns.txt");
			other_fails++;
		end else begin
			while (!aborted && $fgets(line, fd) > 0) begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				tag  = line[0];
				rest = line.substr(1, line.len() - 1);
				case (tag)
					"M": begin
						n = $sscanf(rest, "%h %h %h", w_addr, w_usr, w_shop);
						if (n != 3) begin
							$display("Pattern line could not be read: %s", line);
							other_fails++;
						end else begin
							mem_model[w_addr] = stored_word(w_usr, w_shop);
						end
					end
					"E": begin
						n = $sscanf(rest, "%h %h %h", w_addr, w_usr, w_shop);
						if (n != 3) begin
							$display("Pattern line could not be read: %s", line);
							other_fails++;
						end else begin
							check_word(mem_model[w_addr], stored_word(w_usr, w_shop), w_addr);
						end
					end
					"C": begin
						n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h", c_act, c_nid,
							c_uid, c_hs, c_sid, c_item, c_num, c_amnt, c_err, c_info);
						if (n != 10) begin
							$display("Pattern line could not be read: %s", line);
							other_fails++;
						end else begin
							cmd_no++;
							run_command(c_act, c_nid, c_uid, c_hs, c_sid, c_item, c_num,
								c_amnt, err_t'(c_err), c_info, cmd_no);
						end
					end
					default: begin
						$display("Pattern line has an unknown tag: %s", line);
						other_fails++;
					end
				endcase
			end
			$fclose(fd);
		end
		if (cmd_no == 0) begin
			$display("No commands were found in the pattern file");
			other_fails++;
		end
		if (pulse_total != cmd_no) begin
			$display("out_valid pulsed %0d times for %0d commands", pulse_total, cmd_no);
			other_fails++;
		end

		total = err_fails + info_fails + flag_fails + word_fails + other_fails + proto_fails;
		$display("Errors: err_msg %0d, out_info %0d, flags %0d, memory %0d, other %0d",
			err_fails, info_fails, flag_fails, word_fails, other_fails + proto_fails);
		if (total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/os_top.sv ====
/*
 * Shop-account controller top level
 * Host pulses in, account memory bus out
 */
`timescale 1ns/1ps
`default_nettype none

module os_top import os_pkg::*, os_mem_pkg::*; (
	input  logic        clk,
	input  logic        inf,
	// Host side
	input  logic [31:0] d,
	input  logic        id_valid,
	input  logic        act_valid,
	input  logic        item_valid,
	input  logic        num_valid,
	input  logic        amnt_valid,
	output logic        out_valid,
	output logic        complete,
	output err_t        err_msg,
	output logic [31:0] out_info,
	// Account memory side
	output logic        mem_req_valid,
	input  logic        mem_req_ready,
	output logic        mem_r_wb,
	output mem_addr_t   mem_addr,
	output mem_word_t   mem_wdata,
	input  logic        mem_resp_valid,
	input  mem_word_t   mem_rdata
);

	logic done;

	cmd_if  cmd_bus ();
	acct_if acct_bus ();

	cmd_decode u_decode (
		.clk, .inf, .d, .id_valid, .act_valid, .item_valid, .num_valid, .amnt_valid,
		.cmd (cmd_bus.decode)
	);

	acct_bridge u_bridge (
		.clk, .inf,
		.cmd  (cmd_bus.bridge),
		.acct (acct_bus.bridge),
		.mem_req_valid, .mem_req_ready, .mem_r_wb, .mem_addr, .mem_wdata,
		.mem_resp_valid, .mem_rdata,
		.done
	);

	trade_exec u_exec (
		.clk, .inf,
		.acct (acct_bus.exec)
	);

	result_format u_result (
		.clk, .inf,
		.acct (acct_bus.exec),
		.done, .out_valid, .complete, .err_msg, .out_info
	);

endmodule

`default_nettype wire

// ==== src/result_format.sv ====
/*
 * Host result register
 * out_valid pulse, err_msg, complete and out_info
 */
`timescale 1ns/1ps
`default_nettype none

module result_format import os_pkg::*; (
	input  logic        clk,
	input  logic        inf,
	acct_if.exec        acct,
	input  logic        done,
	output logic        out_valid,
	output logic        complete,
	output err_t        err_msg,
	output logic [31:0] out_info
);

	logic [31:0] info_nx;

	// Zero on any failure
	always_comb begin
		info_nx = '0;
		if (acct.err == No_Err) begin
			case (acct.act)
				Buy:     info_nx = acct.new_usr.user_info;
				Deposit: info_nx = {16'd0, acct.new_usr.user_info.money};
				Check:   info_nx = acct.info;
				default: info_nx = '0;
			endcase
		end
	end

	// One-cycle result after the bridge reports the end
	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			out_valid <= 1'b0;
			complete  <= 1'b0;
			err_msg   <= No_Err;
			out_info  <= '0;
		end else begin
			out_valid <= done;
			complete  <= done && (acct.err == No_Err);
			err_msg   <= done ? acct.err : No_Err;
			out_info  <= done ? info_nx : '0;
		end
	end

endmodule

`default_nettype wire

// ==== src/trade_exec.sv ====
/*
 * Buy, deposit and check arithmetic
 * Error priority and updated records, registered in one cycle
 */
`timescale 1ns/1ps
`default_nettype none

module trade_exec import os_pkg::*; (
	input  logic clk,
	input  logic inf,
	acct_if.exec acct
);

	item_num_t   usr_inv;
	item_num_t   slr_inv;
	logic [8:0]  price;
	logic [5:0]  exp_unit;
	logic [6:0]  fee;
	logic [14:0] goods;
	logic [15:0] cost;
	logic [6:0]  inv_sum;
	logic [11:0] exp_gain;
	logic [12:0] exp_sum;
	logic        promote;
	logic [16:0] slr_sum;
	logic [16:0] dep_sum;
	logic        wallet_full;
	err_t        buy_err;
	account_t    buy_usr;
	account_t    buy_slr;
	account_t    dep_usr;
	logic [31:0] chk_info;

	// --------------------------------------------------
	// Item and level lookups
	always_comb begin
		case (acct.item)
			Large: begin
				usr_inv  = acct.usr_acct.shop_info.large_num;
				slr_inv  = acct.slr_acct.shop_info.large_num;
				price    = PRICE_LARGE;
				exp_unit = EXP_LARGE;
			end
			Medium: begin
				usr_inv  = acct.usr_acct.shop_info.medium_num;
				slr_inv  = acct.slr_acct.shop_info.medium_num;
				price    = PRICE_MEDIUM;
				exp_unit = EXP_MEDIUM;
			end
			Small: begin
				usr_inv  = acct.usr_acct.shop_info.small_num;
				slr_inv  = acct.slr_acct.shop_info.small_num;
				price    = PRICE_SMALL;
				exp_unit = EXP_SMALL;
			end
			default: begin
				usr_inv  = '0;
				slr_inv  = '0;
				price    = '0;
				exp_unit = '0;
			end
		endcase
		case (acct.usr_acct.shop_info.level)
			Platinum: fee = FEE_PLATINUM;
			Gold:     fee = FEE_GOLD;
			Silver:   fee = FEE_SILVER;
			default:  fee = FEE_COPPER;
		endcase
	end

	// Sums sized to hold their carries
	assign goods    = 15'(acct.item_num) * 15'(price);
	assign cost     = 16'(goods) + 16'(fee);
	assign inv_sum  = 7'(usr_inv) + 7'(acct.item_num);
	assign exp_gain = 12'(acct.item_num) * 12'(exp_unit);
	assign exp_sum  = 13'(acct.usr_acct.shop_info.exp) + 13'(exp_gain);
	assign slr_sum  = 17'(acct.slr_acct.user_info.money) + 17'(goods);
	assign dep_sum  = 17'(acct.usr_acct.user_info.money) + 17'(acct.amount);

	assign wallet_full = (dep_sum >= 17'(MONEY_MAX));

	always_comb begin
		case (acct.usr_acct.shop_info.level)
			Copper:  promote = (exp_sum >= EXP_TO_SILVER);
			Silver:  promote = (exp_sum >= EXP_TO_GOLD);
			Gold:    promote = (exp_sum >= EXP_TO_PLATINUM);
			default: promote = 1'b0;
		endcase
	end

	// Buy error priority
	always_comb begin
		if (inv_sum > INV_MAX)
			buy_err = INV_Full;
		else if (slr_inv < acct.item_num)
			buy_err = INV_Not_Enough;
		else if (cost > acct.usr_acct.user_info.money)
			buy_err = Out_of_money;
		else
			buy_err = No_Err;
	end

	// --------------------------------------------------
	// Updated records
	always_comb begin
		buy_usr = acct.usr_acct;
		buy_slr = acct.slr_acct;
		case (acct.item)
			Large: begin
				buy_usr.shop_info.large_num = inv_sum[5:0];
				buy_slr.shop_info.large_num = slr_inv - acct.item_num;
			end
			Medium: begin
				buy_usr.shop_info.medium_num = inv_sum[5:0];
				buy_slr.shop_info.medium_num = slr_inv - acct.item_num;
			end
			Small: begin
				buy_usr.shop_info.small_num = inv_sum[5:0];
				buy_slr.shop_info.small_num = slr_inv - acct.item_num;
			end
			default: ;
		endcase
		// Exp clears on promotion
		if (promote) begin
			buy_usr.shop_info.level = level_t'(acct.usr_acct.shop_info.level - 2'd1);
			buy_usr.shop_info.exp   = '0;
		end else begin
			buy_usr.shop_info.exp = exp_sum[11:0];
		end
		buy_usr.user_info.money                  = acct.usr_acct.user_info.money - cost;
		buy_usr.user_info.shop_history.item_ID   = acct.item;
		buy_usr.user_info.shop_history.item_num  = acct.item_num;
		buy_usr.user_info.shop_history.seller_ID = acct.slr_id;
		// Seller income saturates
		buy_slr.user_info.money = wallet_sat(slr_sum);
		dep_usr                 = acct.usr_acct;
		dep_usr.user_info.money = dep_sum[15:0];
	end

	function automatic money_t wallet_sat(input logic [16:0] sum);
		return (sum >= 17'(MONEY_MAX)) ? MONEY_MAX : sum[15:0];
	endfunction

	// Check answer is seller stock or own money
	assign chk_info = acct.has_seller
		? {14'd0, acct.slr_acct.shop_info.large_num, acct.slr_acct.shop_info.medium_num,
			acct.slr_acct.shop_info.small_num}
		: {16'd0, acct.usr_acct.user_info.money};

	// --------------------------------------------------
	// Result registers
	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			acct.exec_done <= 1'b0;
			acct.err       <= No_Err;
			acct.write_usr <= 1'b0;
			acct.write_slr <= 1'b0;
		end else begin
			acct.exec_done <= acct.exec_start;
			if (acct.exec_start) begin
				case (acct.act)
					Buy: begin
						acct.err       <= buy_err;
						acct.write_usr <= (buy_err == No_Err);
						acct.write_slr <= (buy_err == No_Err);
					end
					Deposit: begin
						acct.err       <= wallet_full ? Wallet_is_Full : No_Err;
						acct.write_usr <= !wallet_full;
						acct.write_slr <= 1'b0;
					end
					default: begin
						acct.err       <= No_Err;
						acct.write_usr <= 1'b0;
						acct.write_slr <= 1'b0;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (acct.exec_start) begin
			acct.new_usr <= (acct.act == Deposit) ? dep_usr : buy_usr;
			acct.new_slr <= buy_slr;
			acct.info    <= chk_info;
		end
	end

endmodule

`default_nettype wire

// ==== src/acct_bridge.sv ====
/*
 * Account memory sequencer
 * Reads user and seller, starts exec, writes back changed records
 */
`timescale 1ns/1ps
`default_nettype none

module acct_bridge import os_pkg::*, os_mem_pkg::*; (
	input  logic      clk,
	input  logic      inf,
	cmd_if.bridge     cmd,
	acct_if.bridge    acct,
	output logic      mem_req_valid,
	input  logic      mem_req_ready,
	output logic      mem_r_wb,
	output mem_addr_t mem_addr,
	output mem_word_t mem_wdata,
	input  logic      mem_resp_valid,
	input  mem_word_t mem_rdata,
	output logic      done
);

	typedef enum logic [2:0] {
		B_IDLE, B_RD_USR, B_RD_SLR, B_EXEC, B_WAIT, B_WR_USR, B_WR_SLR
	} bstate_t;

	bstate_t  state;
	logic     req_valid;
	logic     need_slr;
	user_id_t usr_id;
	user_id_t slr_id;

	// --------------------------------------------------
	// Record packing in memory byte order
	function automatic account_t unpack_word(input mem_word_t w);
		account_t a;
		a.user_info = user_info_t'(lane_swap(w[WORD_W-1 -: HALF_W]));
		a.shop_info = shop_info_t'(lane_swap(w[HALF_W-1:0]));
		return a;
	endfunction

	function automatic mem_word_t pack_word(input account_t a);
		return {lane_swap(a.user_info), lane_swap(a.shop_info)};
	endfunction

	// Seller record only for buy or seller check
	assign need_slr = (acct.act == Buy) || (acct.act == Check && acct.has_seller);

	assign cmd.cmd_ready   = (state == B_IDLE);
	assign acct.exec_start = (state == B_EXEC);

	// --------------------------------------------------
	// Data FSM, one request outstanding at most
	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			state     <= B_IDLE;
			req_valid <= 1'b0;
		end else begin
			if (req_valid && mem_req_ready)
				req_valid <= 1'b0;
			case (state)
				B_IDLE: begin
					if (cmd.cmd_valid) begin
						state     <= B_RD_USR;
						req_valid <= 1'b1;
					end
				end
				B_RD_USR: begin
					if (mem_resp_valid) begin
						state     <= need_slr ? B_RD_SLR : B_EXEC;
						req_valid <= need_slr;
					end
				end
				B_RD_SLR: if (mem_resp_valid) state <= B_EXEC;
				B_EXEC:   state <= B_WAIT;
				B_WAIT: begin
					if (acct.exec_done) begin
						if (acct.write_usr)
							state <= B_WR_USR;
						else if (acct.write_slr)
							state <= B_WR_SLR;
						else
							state <= B_IDLE;
						req_valid <= acct.write_usr || acct.write_slr;
					end
				end
				B_WR_USR: begin
					if (mem_resp_valid) begin
						state     <= acct.write_slr ? B_WR_SLR : B_IDLE;
						req_valid <= acct.write_slr;
					end
				end
				B_WR_SLR: if (mem_resp_valid) state <= B_IDLE;
				default:  state <= B_IDLE;
			endcase
		end
	end

	// Command latch and fetched records
	always_ff @(posedge clk) begin
		if (state == B_IDLE && cmd.cmd_valid) begin
			usr_id          <= cmd.usr_id;
			slr_id          <= cmd.slr_id;
			acct.slr_id     <= cmd.slr_id;
			acct.act        <= cmd.act;
			acct.item       <= cmd.item;
			acct.item_num   <= cmd.item_num;
			acct.has_seller <= cmd.has_seller;
			acct.amount     <= cmd.amount;
		end
		if (state == B_RD_USR && mem_resp_valid)
			acct.usr_acct <= unpack_word(mem_rdata);
		if (state == B_RD_SLR && mem_resp_valid)
			acct.slr_acct <= unpack_word(mem_rdata);
	end

	// --------------------------------------------------
	// Memory request fields
	assign mem_req_valid = req_valid;
	assign mem_r_wb      = (state == B_RD_USR || state == B_RD_SLR);
	assign mem_addr      = mem_addr_t'((state == B_RD_SLR || state == B_WR_SLR) ? slr_id : usr_id);
	assign mem_wdata     = pack_word((state == B_WR_SLR) ? acct.new_slr : acct.new_usr);

	// End of command, after exec or the last write ack
	assign done = (state == B_WAIT && acct.exec_done && !acct.write_usr && !acct.write_slr)
		|| (state == B_WR_USR && mem_resp_valid && !acct.write_slr)
		|| (state == B_WR_SLR && mem_resp_valid);

endmodule

`default_nettype wire

// ==== src/cmd_decode.sv ====
/*
 * Host input sequencer
 * Captures command fields and times the check window
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_decode import os_pkg::*; (
	input  logic        clk,
	input  logic        inf,
	input  logic [31:0] d,
	input  logic        id_valid,
	input  logic        act_valid,
	input  logic        item_valid,
	input  logic        num_valid,
	input  logic        amnt_valid,
	cmd_if.decode       cmd
);

	typedef enum logic [2:0] {
		S_IDLE, S_ITEM, S_NUM, S_SLR, S_AMNT, S_CHK, S_ISSUE
	} state_t;

	state_t     state;
	state_t     state_nx;
	logic [2:0] win_cnt;

	// --------------------------------------------------
	// Input sequence per action
	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE: begin
				if (act_valid) begin
					case (action_t'(d[3:0]))
						Buy:     state_nx = S_ITEM;
						Deposit: state_nx = S_AMNT;
						Check:   state_nx = S_CHK;
						default: state_nx = S_IDLE;
					endcase
				end
			end
			S_ITEM: if (item_valid) state_nx = S_NUM;
			S_NUM:  if (num_valid) state_nx = S_SLR;
			S_SLR:  if (id_valid) state_nx = S_ISSUE;
			S_AMNT: if (amnt_valid) state_nx = S_ISSUE;
			S_CHK: begin
				// Seller id wins over the window end
				if (id_valid || win_cnt == CHECK_WAIT - 3'd1)
					state_nx = S_ISSUE;
			end
			// Hold under back-pressure
			S_ISSUE: if (cmd.cmd_ready) state_nx = S_IDLE;
			default: state_nx = S_IDLE;
		endcase
	end

	assign cmd.cmd_valid = (state == S_ISSUE);

	// Control state and the sticky user id
	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			state          <= S_IDLE;
			win_cnt        <= 3'd0;
			cmd.usr_id     <= '0;
			cmd.has_seller <= 1'b0;
		end else begin
			state   <= state_nx;
			win_cnt <= (state == S_CHK) ? win_cnt + 3'd1 : 3'd0;
			// Kept across commands unless a new id comes
			if (state == S_IDLE && id_valid)
				cmd.usr_id <= d[7:0];
			if (state == S_IDLE && act_valid)
				cmd.has_seller <= 1'b0;
			else if ((state == S_SLR || state == S_CHK) && id_valid)
				cmd.has_seller <= 1'b1;
		end
	end

	// Field capture
	always_ff @(posedge clk) begin
		if (state == S_IDLE && act_valid)
			cmd.act <= action_t'(d[3:0]);
		if (state == S_ITEM && item_valid)
			cmd.item <= item_t'(d[1:0]);
		if (state == S_NUM && num_valid)
			cmd.item_num <= d[5:0];
		if ((state == S_SLR || state == S_CHK) && id_valid)
			cmd.slr_id <= d[7:0];
		if (state == S_AMNT && amnt_valid)
			cmd.amount <= d[15:0];
	end

endmodule

`default_nettype wire

// ==== src/os_if.sv ====
/*
 * cmd_if carries a decoded command from decode to the bridge
 * acct_if carries accounts to the executor and its results back
 */
`timescale 1ns/1ps
`default_nettype none

interface cmd_if import os_pkg::*; ();
	// Fields hold while cmd_valid is high
	logic      cmd_valid;
	logic      cmd_ready;
	action_t   act;
	item_t     item;
	item_num_t item_num;
	user_id_t  usr_id;
	user_id_t  slr_id;
	logic      has_seller;
	money_t    amount;

	modport decode (
		output cmd_valid, act, item, item_num, usr_id, slr_id, has_seller, amount,
		input  cmd_ready
	);
	modport bridge (
		input  cmd_valid, act, item, item_num, usr_id, slr_id, has_seller, amount,
		output cmd_ready
	);
endinterface

interface acct_if import os_pkg::*; ();
	// Request side, exec_start is a single pulse
	logic      exec_start;
	action_t   act;
	item_t     item;
	item_num_t item_num;
	user_id_t  slr_id;
	logic      has_seller;
	money_t    amount;
	account_t  usr_acct;
	account_t  slr_acct;
	// Result side, valid from exec_done until the next start
	logic        exec_done;
	err_t        err;
	logic        write_usr;
	logic        write_slr;
	account_t    new_usr;
	account_t    new_slr;
	logic [31:0] info;

	modport bridge (
		output exec_start, act, item, item_num, slr_id, has_seller, amount,
		       usr_acct, slr_acct,
		input  exec_done, err, write_usr, write_slr, new_usr, new_slr, info
	);
	modport exec (
		input  exec_start, act, item, item_num, slr_id, has_seller, amount,
		       usr_acct, slr_acct,
		output exec_done, err, write_usr, write_slr, new_usr, new_slr, info
	);
endinterface

`default_nettype wire

// ==== src/os_mem_pkg.sv ====
/*
 * Account memory layout
 * Address and word widths, byte-lane order of a stored record
 */
`default_nettype none

package os_mem_pkg;

	localparam int ADDR_W = 8;
	localparam int WORD_W = 64;
	// User half is upper, shop half is lower
	localparam int HALF_W = WORD_W / 2;

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [WORD_W-1:0] mem_word_t;

	// Bytes are stored reversed inside each half
	function automatic logic [HALF_W-1:0] lane_swap(input logic [HALF_W-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

`default_nettype wire

// ==== src/os_pkg.sv ====
/*
 * Shop domain types for the account controller
 * Actions, items, levels, error codes and account records
 * Prices, experience, delivery fees and promotion thresholds
 */
`default_nettype none

package os_pkg;

	// Host command codes
	typedef enum logic [3:0] {
		No_action = 4'd0,
		Buy       = 4'd1,
		Check     = 4'd2,
		Deposit   = 4'd4
	} action_t;

	typedef enum logic [1:0] {No_item, Large, Medium, Small} item_t;

	// Promotion steps one code down toward Platinum
	typedef enum logic [1:0] {Platinum, Gold, Silver, Copper} level_t;

	typedef enum logic [3:0] {
		No_Err         = 4'b0000,
		INV_Not_Enough = 4'b0010,
		Out_of_money   = 4'b0011,
		INV_Full       = 4'b0100,
		Wallet_is_Full = 4'b1000
	} err_t;

	typedef logic [7:0]  user_id_t;
	typedef logic [5:0]  item_num_t;
	typedef logic [15:0] money_t;

	// --------------------------------------------------
	// Account records
	typedef struct packed {
		item_num_t   large_num;
		item_num_t   medium_num;
		item_num_t   small_num;
		level_t      level;
		logic [11:0] exp;
	} shop_info_t;

	typedef struct packed {
		item_t     item_ID;
		item_num_t item_num;
		user_id_t  seller_ID;
	} history_t;

	typedef struct packed {
		money_t   money;
		history_t shop_history;
	} user_info_t;

	typedef struct packed {
		shop_info_t shop_info;
		user_info_t user_info;
	} account_t;

	// --------------------------------------------------
	// Goods price and experience per piece
	localparam logic [8:0] PRICE_LARGE  = 9'd300;
	localparam logic [8:0] PRICE_MEDIUM = 9'd200;
	localparam logic [8:0] PRICE_SMALL  = 9'd100;
	localparam logic [5:0] EXP_LARGE    = 6'd60;
	localparam logic [5:0] EXP_MEDIUM   = 6'd40;
	localparam logic [5:0] EXP_SMALL    = 6'd20;

	// Delivery fee by level
	localparam logic [6:0] FEE_PLATINUM = 7'd10;
	localparam logic [6:0] FEE_GOLD     = 7'd30;
	localparam logic [6:0] FEE_SILVER   = 7'd50;
	localparam logic [6:0] FEE_COPPER   = 7'd70;

	// Exp needed to leave the current level
	localparam logic [12:0] EXP_TO_SILVER   = 13'd1000;
	localparam logic [12:0] EXP_TO_GOLD     = 13'd2500;
	localparam logic [12:0] EXP_TO_PLATINUM = 13'd4000;

	localparam logic [6:0] INV_MAX    = 7'd63;
	localparam money_t     MONEY_MAX  = 16'd65535;
	// Check window for a seller id, in cycles
	localparam logic [2:0] CHECK_WAIT = 3'd6;

endpackage

`default_nettype wire
